// File: hw/fb_axi_pkg.sv
package fb_axi_pkg;

  // frame-buffer bus sizing
  localparam int fb_addr_bits = 10;
  localparam int fb_data_bits = 16;
  localparam int fb_words = 768;

  // cycles from an accepted read address to rvalid
  localparam int fb_read_latency = 2;

  localparam logic [1:0] resp_okay = 2'b00;

  // read address channel, driven by the master
  typedef struct packed {
    logic [fb_addr_bits-1:0] araddr;
    logic                    arvalid;
  } axi_ar_t;

  // read data channel, driven by the slave
  // the master always takes data, so no rready
  typedef struct packed {
    logic [fb_data_bits-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
  } axi_r_t;

  // host side load port into the frame buffer
  typedef struct packed {
    logic                    we;
    logic [fb_addr_bits-1:0] addr;
    logic [fb_data_bits-1:0] data;
  } fb_write_t;

endpackage

// File: hw/vga_timing_pkg.sv
package vga_timing_pkg;

  // reduced display mode, swap these for 640x480
  localparam int h_visible = 32;
  localparam int h_front_porch = 2;
  localparam int h_sync_pulse = 4;
  localparam int h_back_porch = 2;
  localparam int h_whole_line = 40;

  localparam int v_visible = 24;
  localparam int v_front_porch = 1;
  localparam int v_sync_pulse = 2;
  localparam int v_back_porch = 2;
  localparam int v_whole_frame = 29;

  // raster counter widths
  localparam int x_bits = 6;
  localparam int y_bits = 5;

  localparam int pixel_bits = 12;

  // what the stream remembers about a slot while its read is in flight
  typedef struct packed {
    logic                                visible;
    logic                                vsync;
    logic                                hsync;
    logic [fb_axi_pkg::fb_addr_bits-1:0] addr;
  } pixel_meta_t;

  // one pixel as handed to the consumer
  typedef struct packed {
    logic                                visible;
    logic                                hsync;
    logic                                vsync;
    logic [fb_axi_pkg::fb_addr_bits-1:0] addr;
    logic [pixel_bits-1:0]               color;
  } pixel_out_t;

endpackage

// File: hw/vga_sync.sv
module vga_sync (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              advance,
  output logic                              visible,
  output logic                              hsync,
  output logic                              vsync,
  output logic [vga_timing_pkg::x_bits-1:0] column,
  output logic [vga_timing_pkg::y_bits-1:0] row
);
  import vga_timing_pkg::*;

  localparam logic [x_bits-1:0] column_last = x_bits'(h_whole_line - 1);
  localparam logic [y_bits-1:0] row_last = y_bits'(v_whole_frame - 1);

  // both sync pulses begin right after the front porch
  localparam logic [x_bits-1:0] hsync_start = x_bits'(h_visible + h_front_porch);
  localparam logic [x_bits-1:0] hsync_end =
    x_bits'(h_visible + h_front_porch + h_sync_pulse);
  localparam logic [y_bits-1:0] vsync_start = y_bits'(v_visible + v_front_porch);
  localparam logic [y_bits-1:0] vsync_end =
    y_bits'(v_visible + v_front_porch + v_sync_pulse);

  localparam logic [x_bits-1:0] column_visible = x_bits'(h_visible);
  localparam logic [y_bits-1:0] row_visible = y_bits'(v_visible);

  logic column_wrap;
  logic row_wrap;

  assign column_wrap = (column == column_last);
  assign row_wrap = (row == row_last);

  // column moves once per advance
  always_ff @(posedge clk) begin
    if (reset) begin
      column <= '0;
    end else if (advance) begin
      if (column_wrap) begin
        column <= '0;
      end else begin
        column <= column + 1'b1;
      end
    end
  end

  // row steps at the end of each line
  always_ff @(posedge clk) begin
    if (reset) begin
      row <= '0;
    end else if (advance && column_wrap) begin
      if (row_wrap) begin
        row <= '0;
      end else begin
        row <= row + 1'b1;
      end
    end
  end

  // active high syncs, decoded straight from the counters
  always_comb begin
    visible = (column < column_visible) && (row < row_visible);
    hsync = (column >= hsync_start) && (column < hsync_end);
    vsync = (row >= vsync_start) && (row < vsync_end);
  end

endmodule

// File: hw/sync_fifo.sv
module sync_fifo #(
  parameter type data_t = logic [7:0],
  parameter int depth_log2 = 3,
  parameter int almost_full_margin = 2
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  w_inc,
  input  data_t w_data,
  output logic  w_full,
  output logic  w_almost_full,
  input  logic  r_inc,
  output data_t r_data,
  output logic  r_empty
);

  localparam int depth = 1 << depth_log2;
  localparam logic [depth_log2:0] depth_count = (depth_log2 + 1)'(depth);
  localparam logic [depth_log2:0] margin_count = (depth_log2 + 1)'(almost_full_margin);

  data_t mem [depth];

  // pointers carry one extra wrap bit to tell full from empty
  logic [depth_log2:0] wr_ptr;
  logic [depth_log2:0] rd_ptr;
  logic [depth_log2:0] used;
  logic [depth_log2:0] free_space;
  logic                do_write;
  logic                do_read;

  assign used = wr_ptr - rd_ptr;
  assign free_space = depth_count - used;

  assign w_full = (used == depth_count);
  assign w_almost_full = (free_space <= margin_count);
  assign r_empty = (wr_ptr == rd_ptr);

  assign do_write = w_inc && !w_full;
  assign do_read = r_inc && !r_empty;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr[depth_log2-1:0]] <= w_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // head entry is always on show
  assign r_data = mem[rd_ptr[depth_log2-1:0]];

endmodule

// File: hw/vga_fb_pixel_stream.sv
module vga_fb_pixel_stream (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       enable,
  output fb_axi_pkg::axi_ar_t        ar,
  input  logic                       arready,
  input  fb_axi_pkg::axi_r_t         r,
  output vga_timing_pkg::pixel_out_t pixel,
  output logic                       pixel_valid
);
  import vga_timing_pkg::*;
  import fb_axi_pkg::*;

  typedef enum logic {
    idle,
    reading
  } read_state_t;

  logic              slot_visible;
  logic              slot_hsync;
  logic              slot_vsync;
  logic [x_bits-1:0] slot_column;
  logic [y_bits-1:0] slot_row;
  logic              advance;

  logic [fb_addr_bits-1:0] slot_addr;
  pixel_meta_t             slot_meta;

  pixel_meta_t meta_p1;
  logic        advance_p1;
  logic        enable_p1;

  read_state_t             state;
  read_state_t             next_state;
  logic                    read_ok;
  logic                    read_start;
  logic                    read_start_p1;
  logic                    read_accepted;
  logic                    arvalid_q;
  logic [fb_addr_bits-1:0] araddr_q;

  logic        fifo_almost_full;
  logic        fifo_empty;
  logic        fifo_pop;
  pixel_meta_t fifo_head;

  // visible slots only move on once their read is under way
  assign advance = !fifo_almost_full && (read_start || (!slot_visible && enable));

  vga_sync sync_i (
    .clk    (clk),
    .reset  (reset),
    .advance(advance),
    .visible(slot_visible),
    .hsync  (slot_hsync),
    .vsync  (slot_vsync),
    .column (slot_column),
    .row    (slot_row)
  );

  // address is formed in blanking too, it simply never gets read
  assign slot_addr = fb_addr_bits'(h_visible) * fb_addr_bits'(slot_row)
                   + fb_addr_bits'(slot_column);

  assign slot_meta = '{
    visible: slot_visible,
    vsync:   slot_vsync,
    hsync:   slot_hsync,
    addr:    slot_addr
  };

  // one stage to break up the multiply
  always_ff @(posedge clk) begin
    meta_p1 <= slot_meta;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      advance_p1 <= 1'b0;
      enable_p1 <= 1'b0;
    end else begin
      advance_p1 <= advance;
      enable_p1 <= enable;
    end
  end

  assign read_ok = enable_p1 && meta_p1.visible && !fifo_almost_full;
  assign read_accepted = arvalid_q && arready;

  // a new read may only start once the previous address is taken
  always_comb begin
    next_state = state;
    read_start = 1'b0;
    case (state)
      idle: begin
        if (read_ok) begin
          next_state = reading;
          read_start = 1'b1;
        end
      end
      reading: begin
        if (read_accepted) begin
          if (read_ok) begin
            read_start = 1'b1;
          end else begin
            next_state = idle;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      read_start_p1 <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      state <= next_state;
      read_start_p1 <= read_start;
      if (read_start_p1) begin
        arvalid_q <= 1'b1;
      end else if (read_accepted) begin
        arvalid_q <= 1'b0;
      end
    end
  end

  // meta_p1 still holds the slot whose read started last cycle
  always_ff @(posedge clk) begin
    if (read_start_p1) begin
      araddr_q <= meta_p1.addr;
    end
  end

  assign ar = '{araddr: araddr_q, arvalid: arvalid_q};

  sync_fifo #(
    .data_t            (pixel_meta_t),
    .depth_log2        (3),
    .almost_full_margin(2)
  ) meta_fifo_i (
    .clk          (clk),
    .reset        (reset),
    .w_inc        (advance_p1),
    .w_data       (meta_p1),
    .w_full       (),
    .w_almost_full(fifo_almost_full),
    .r_inc        (fifo_pop),
    .r_data       (fifo_head),
    .r_empty      (fifo_empty)
  );

  // blanking slots leave at once, visible ones wait for their data
  assign fifo_pop = !fifo_empty && (!fifo_head.visible || r.rvalid);

  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= fifo_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      pixel <= '{
        visible: fifo_head.visible,
        hsync:   fifo_head.hsync,
        vsync:   fifo_head.vsync,
        addr:    fifo_head.addr,
        color:   fifo_head.visible ? r.rdata[pixel_bits-1:0] : '0
      };
    end
  end

endmodule

// File: hw/fb_sram.sv
module fb_sram (
  input  logic                  clk,
  input  logic                  reset,
  input  fb_axi_pkg::fb_write_t host_wr,
  input  fb_axi_pkg::axi_ar_t   ar,
  output logic                  arready,
  output fb_axi_pkg::axi_r_t    r
);
  import fb_axi_pkg::*;

  logic [fb_data_bits-1:0] mem [fb_words];

  logic [fb_read_latency-1:0] valid_pipe;
  logic [fb_addr_bits-1:0]    addr_pipe [fb_read_latency];
  logic                       ar_fire;

  // comes up one cycle after reset drops
  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
    end else begin
      arready <= 1'b1;
    end
  end

  assign ar_fire = ar.arvalid && arready;

  always_ff @(posedge clk) begin
    if (host_wr.we) begin
      mem[host_wr.addr] <= host_wr.data;
    end
  end

  // fixed latency, one address per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= ar_fire;
      for (int i = 1; i < fb_read_latency; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    addr_pipe[0] <= ar.araddr;
    for (int i = 1; i < fb_read_latency; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  assign r = '{
    rdata:  mem[addr_pipe[fb_read_latency-1]],
    rresp:  resp_okay,
    rvalid: valid_pipe[fb_read_latency-1]
  };

endmodule

// File: hw/fb_display_top.sv
module fb_display_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       enable,
  input  fb_axi_pkg::fb_write_t      host_wr,
  output vga_timing_pkg::pixel_out_t pixel,
  output logic                       pixel_valid
);
  import fb_axi_pkg::*;

  // read channel between the stream and the frame buffer
  axi_ar_t ar;
  axi_r_t  r;
  logic    arready;

  vga_fb_pixel_stream stream_i (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .ar         (ar),
    .arready    (arready),
    .r          (r),
    .pixel      (pixel),
    .pixel_valid(pixel_valid)
  );

  fb_sram sram_i (
    .clk    (clk),
    .reset  (reset),
    .host_wr(host_wr),
    .ar     (ar),
    .arready(arready),
    .r      (r)
  );

endmodule

// File: sim/fb_display_properties.sv
module fb_display_properties (
  input logic                       clk,
  input logic                       reset,
  input logic                       enable,
  input fb_axi_pkg::axi_ar_t        ar,
  input logic                       arready,
  input fb_axi_pkg::axi_r_t         r,
  input vga_timing_pkg::pixel_out_t pixel,
  input logic                       pixel_valid
);

  logic enable_seen;

  // set once the consumer has asked for pixels since reset
  always_ff @(posedge clk) begin
    if (reset) begin
      enable_seen <= 1'b0;
    end else if (enable) begin
      enable_seen <= 1'b1;
    end
  end

  // an offered address stays put until the memory takes it
  property ar_held_until_ready;
    @(posedge clk) disable iff (reset)
      (ar.arvalid && !arready) |=> (ar.arvalid && $stable(ar.araddr));
  endproperty

  // no pixel pulse until enable has been raised
  property valid_low_until_enable;
    @(posedge clk) disable iff (reset)
      !enable_seen |-> !pixel_valid;
  endproperty

  // a blanking pixel carries no color and never swallows read data
  property blank_color_zero;
    @(posedge clk) disable iff (reset)
      (pixel_valid && !pixel.visible) |-> (pixel.color == '0 && !$past(r.rvalid));
  endproperty

  ar_hold_a: assert property (ar_held_until_ready)
    else $error("read address dropped or changed before arready");
  reset_a: assert property (valid_low_until_enable)
    else $error("pixel_valid high before enable was ever raised");
  color_a: assert property (blank_color_zero)
    else $error("blanking pixel with nonzero color or dropped read data");

endmodule

bind vga_fb_pixel_stream fb_display_properties props_i (
  .clk        (clk),
  .reset      (reset),
  .enable     (enable),
  .ar         (ar),
  .arready    (arready),
  .r          (r),
  .pixel      (pixel),
  .pixel_valid(pixel_valid)
);

// File: sim/fb_display_tb.sv
module fb_display_tb;
  import vga_timing_pkg::*;
  import fb_axi_pkg::*;

  typedef enum logic [1:0] {
    pat_on,
    pat_off,
    pat_alt,
    pat_rand
  } enable_pattern_t;

  // one table row: how enable behaves and how many pixels may arrive
  typedef struct packed {
    enable_pattern_t pattern;
    logic [15:0]     cycles;
    logic [15:0]     min_pixels;
    logic [15:0]     max_pixels;
  } enable_step_t;

  localparam int frame_slots = h_whole_line * v_whole_frame;
  localparam int watchdog_cycles = 3 * frame_slots * 6 + 2000;
  localparam int idle_tail = 20;
  localparam int step_count = 8;

  // address of the last slot of a frame, found nowhere else in the raster
  localparam int last_slot_addr = h_visible * (v_whole_frame - 1) + h_whole_line - 1;

  // off rows allow only what was already in flight: fifo depth plus two
  enable_step_t steps [step_count] = '{
    '{pat_on,   16'd1000, 16'd250, 16'd1000},
    '{pat_off,  16'd150,  16'd0,   16'd10},
    '{pat_alt,  16'd1000, 16'd160, 16'd520},
    '{pat_rand, 16'd1200, 16'd120, 16'd1200},
    '{pat_off,  16'd100,  16'd0,   16'd10},
    '{pat_on,   16'd1600, 16'd400, 16'd1600},
    '{pat_rand, 16'd600,  16'd60,  16'd600},
    '{pat_off,  16'd60,   16'd0,   16'd10}
  };

  logic       clk = 1'b0;
  logic       reset;
  logic       enable;
  fb_write_t  host_wr;
  pixel_out_t pixel;
  logic       pixel_valid;

  logic [fb_data_bits-1:0] mirror [fb_words];
  logic [31:0]             lfsr_state;

  // reference raster position, advanced once per observed pixel
  int         model_column = 0;
  int         model_row = 0;
  int         total_pixels = 0;
  int         frames_done = 0;
  int         frame_ends_seen = 0;
  int         pixels_at_third_frame = 0;
  logic       enable_seen = 1'b0;
  pixel_out_t expected_px;

  fb_display_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .host_wr    (host_wr),
    .pixel      (pixel),
    .pixel_valid(pixel_valid)
  );

  always #5 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic take_random_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  function automatic pixel_out_t expected_pixel(input int column, input int row);
    pixel_out_t px;
    int         addr;
    addr = h_visible * row + column;
    px.visible = (column < h_visible) && (row < v_visible);
    px.hsync = (column >= h_visible + h_front_porch)
            && (column < h_visible + h_front_porch + h_sync_pulse);
    px.vsync = (row >= v_visible + v_front_porch)
            && (row < v_visible + v_front_porch + v_sync_pulse);
    px.addr = fb_addr_bits'(addr);
    px.color = px.visible ? mirror[addr][pixel_bits-1:0] : '0;
    return px;
  endfunction

  task automatic report_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_pixel(input pixel_out_t expected, input pixel_out_t actual);
    if (actual !== expected) begin
      $display("[FAIL] pixel at column %0d row %0d: expected 0x%h got 0x%h",
               model_column, model_row, expected, actual);
      $display("  addr 0x%h/0x%h color 0x%h/0x%h", expected.addr, actual.addr,
               expected.color, actual.color);
      report_failure();
    end
  endtask

  task automatic check_count(input string what, input int low, input int high,
                             input int actual);
    if (actual < low || actual > high) begin
      if (low == high) begin
        $display("[FAIL] %s: expected 0x%0h got 0x%0h", what, low, actual);
      end else begin
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h to 0x%0h", what, actual, low, high);
      end
      report_failure();
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!reset) begin
      if (enable) begin
        enable_seen = 1'b1;
      end
      if (pixel_valid) begin
        if (!enable_seen) begin
          $display("pixel_valid rose before enable was ever raised");
          report_failure();
        end
        expected_px = expected_pixel(model_column, model_row);
        check_pixel(expected_px, pixel);
        total_pixels++;
        // the DUT marks each frame end with the address of its last slot
        if (pixel.addr == fb_addr_bits'(last_slot_addr)) begin
          frame_ends_seen++;
          if (frame_ends_seen == 3) begin
            pixels_at_third_frame = total_pixels;
          end
        end
        model_column++;
        if (model_column == h_whole_line) begin
          model_column = 0;
          model_row++;
          if (model_row == v_whole_frame) begin
            model_row = 0;
            frames_done++;
          end
        end
      end
    end
  end

  task automatic run_step(input int index, input enable_step_t step);
    int          start_count;
    int          tail_count;
    logic [31:0] bits;
    start_count = total_pixels;
    tail_count = 0;
    for (int i = 0; i < int'(step.cycles); i++) begin
      if (i == int'(step.cycles) - idle_tail) begin
        tail_count = total_pixels;
      end
      @(posedge clk);
      case (step.pattern)
        pat_on: enable <= 1'b1;
        pat_off: enable <= 1'b0;
        pat_alt: enable <= (i % 2 == 0);
        default: begin
          take_random_bits(1, bits);
          enable <= bits[0];
        end
      endcase
    end
    check_count($sformatf("pixel_valid count in step %0d", index), int'(step.min_pixels),
                int'(step.max_pixels), total_pixels - start_count);
    // the pipe must have drained well before an idle row ends
    if (step.pattern == pat_off) begin
      check_count($sformatf("pixel_valid count late in idle step %0d", index), 0, 0,
                  total_pixels - tail_count);
    end
  endtask

  initial begin
    logic [31:0] bits;
    reset = 1'b1;
    enable = 1'b0;
    host_wr = '0;
    lfsr_state = 32'h9f19_e2a7;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // fill the frame buffer with random words and keep a copy
    for (int a = 0; a < fb_words; a++) begin
      take_random_bits(fb_data_bits, bits);
      @(posedge clk);
      host_wr <= '{we: 1'b1, addr: fb_addr_bits'(a), data: bits[fb_data_bits-1:0]};
      mirror[a] = bits[fb_data_bits-1:0];
    end
    @(posedge clk);
    host_wr <= '0;

    repeat (20) @(posedge clk);
    check_count("pixel_valid count before enable", 0, 0, total_pixels);

    for (int s = 0; s < step_count; s++) begin
      run_step(s, steps[s]);
    end

    // finish the third frame with enable held high
    while (frames_done < 3) begin
      @(posedge clk);
      enable <= 1'b1;
    end
    check_count("pixel_valid count over three frames", 3 * frame_slots, 3 * frame_slots,
                pixels_at_third_frame);

    $display("Test completed successfully");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: pixel stream stalled");
    $display("Test failed");
    $fatal(1);
  end

endmodule

// File: sources.f
hw/fb_axi_pkg.sv
hw/vga_timing_pkg.sv
hw/vga_sync.sv
hw/sync_fifo.sv
hw/vga_fb_pixel_stream.sv
hw/fb_sram.sv
hw/fb_display_top.sv
sim/fb_display_properties.sv
sim/fb_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the frame-buffer scan-out testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sources.f --top-module fb_display_tb \
  -o fb_display_sim > build.log 2>&1 || { cat build.log; echo "FAIL: build"; exit 1; }

./obj_dir/fb_display_sim > sim.log 2>&1

# the log decides the outcome
grep -q "Test completed successfully" sim.log && { echo "PASS"; exit 0; } \
  || { cat sim.log; echo "FAIL"; exit 1; }
